/* list.f */
+incdir+verilog
verilog/periph_pkg.sv
verilog/bus_register.sv
verilog/gpio_sync.sv
verilog/gpio.sv
verilog/timer.sv
verilog/periph_bus.sv
bench/periph_assertions.sv
bench/periph_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module periph_tb -o periph_sim \
    && ./obj_dir/periph_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^sim passed$" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

/* bench/periph_tb.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_tb;

    import periph_pkg::*;

    localparam int reset_cycles = 8;
    localparam int access_cycles = 400;
    localparam int input_cycles = 120;
    localparam int edge_cycles = 200;
    localparam int cycle_budget = reset_cycles + 20 + access_cycles + input_cycles
        + edge_cycles + 80 + 140 + 200;

    logic clk;
    logic reset;
    logic enable;
    logic write_en;
    bus_addr_t addr;
    bus_data_t data_in;
    bus_data_t data_out;
    pin_word_t gpi;
    pin_word_t gpo;
    logic gpio_interrupt;
    logic timer_interrupt;

    // reference model state.
    pin_word_t m_out;
    pin_word_t m_rise;
    pin_word_t m_fall;
    pin_word_t m_sync1;
    pin_word_t m_sync2;
    pin_word_t m_prev;
    logic [15:0] m_reload;
    logic [15:0] m_count;
    bus_data_t m_ctrl;
    logic m_running;
    logic m_gint;
    logic m_tint;

    logic [31:0] rng_state;
    pin_word_t pins_now;
    bus_data_t last_read;
    int errors;
    int test_errors;
    int tests_failed;
    int cycle_no;
    int pulse_log[$];
    string test_name;

    periph_bus uut (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .write_en(write_en),
        .addr(addr),
        .data_in(data_in),
        .data_out(data_out),
        .gpi(gpi),
        .gpo(gpo),
        .gpio_interrupt(gpio_interrupt),
        .timer_interrupt(timer_interrupt)
    );

    bind periph_bus periph_assertions bus_checks (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .data_out(data_out),
        .gpo(gpo),
        .gpio_interrupt(gpio_interrupt),
        .timer_interrupt(timer_interrupt),
        .gpi_level(gpio_unit.in_level),
        .reload(timer_unit.reload)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(cycle_budget * 8);
        $display("TIMEOUT: the run did not finish within its cycle budget");
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bus_data_t model_read(bus_addr_t a);
        bus_addr_t g;
        bus_addr_t t;
        g = a - `GPIO_BASE;
        t = a - `TIMER_BASE;
        if (a >= `GPIO_BASE && a < `GPIO_BASE + `WINDOW_SIZE) begin
            case (g[2:0])
                `GPIO_OUT_LO: return m_out[7:0];
                `GPIO_OUT_HI: return m_out[15:8];
                `GPIO_IN_LO: return m_sync2[7:0];
                `GPIO_IN_HI: return m_sync2[15:8];
                `GPIO_RISE_LO: return m_rise[7:0];
                `GPIO_RISE_HI: return m_rise[15:8];
                `GPIO_FALL_LO: return m_fall[7:0];
                default: return m_fall[15:8];
            endcase
        end
        if (a >= `TIMER_BASE && a < `TIMER_BASE + `WINDOW_SIZE) begin
            case (t[2:0])
                `TIMER_RELOAD_LO: return m_reload[7:0];
                `TIMER_RELOAD_HI: return m_reload[15:8];
                `TIMER_CTRL: return m_ctrl;
                `TIMER_COUNT_LO: return m_count[7:0];
                `TIMER_COUNT_HI: return m_count[15:8];
                default: return 8'h00;
            endcase
        end
        return 8'h00;
    endfunction

    task automatic report_mismatch(string name, logic [15:0] expected, logic [15:0] actual);
        errors++;
        $display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, expected,
                 actual);
    endtask

    // one bus cycle: drive, check at a stable point, then step the model over the edge.
    task automatic bus_cycle(logic en, logic we, bus_addr_t a, bus_data_t d);
        bus_data_t expected_read;
        bus_addr_t g;
        bus_addr_t t;
        logic g_write;
        logic t_write;
        logic ctrl_write;
        logic match;
        pin_word_t n_out;
        pin_word_t n_rise;
        pin_word_t n_fall;
        logic [15:0] n_reload;
        logic [15:0] n_count;
        bus_data_t n_ctrl;
        logic n_running;
        logic n_gint;
        logic n_tint;
        enable = en;
        write_en = we;
        addr = a;
        data_in = d;
        gpi = pins_now;
        #1;
        expected_read = en ? model_read(a) : 8'h00;
        last_read = data_out;
        if (data_out !== expected_read) report_mismatch("data_out", 16'(expected_read),
                                                        16'(data_out));
        if (gpo !== m_out) report_mismatch("gpo", m_out, gpo);
        if (gpio_interrupt !== m_gint) report_mismatch("gpio_interrupt", 16'(m_gint),
                                                       16'(gpio_interrupt));
        if (timer_interrupt !== m_tint) report_mismatch("timer_interrupt", 16'(m_tint),
                                                        16'(timer_interrupt));
        if (timer_interrupt === 1'b1) pulse_log.push_back(cycle_no);
        g = a - `GPIO_BASE;
        t = a - `TIMER_BASE;
        g_write = en && we && (a >= `GPIO_BASE) && (a < `GPIO_BASE + `WINDOW_SIZE);
        t_write = en && we && (a >= `TIMER_BASE) && (a < `TIMER_BASE + `WINDOW_SIZE);
        n_out = m_out;
        n_rise = m_rise;
        n_fall = m_fall;
        n_reload = m_reload;
        n_ctrl = m_ctrl;
        if (g_write) begin
            case (g[2:0])
                `GPIO_OUT_LO: n_out[7:0] = d;
                `GPIO_OUT_HI: n_out[15:8] = d;
                `GPIO_RISE_LO: n_rise[7:0] = d;
                `GPIO_RISE_HI: n_rise[15:8] = d;
                `GPIO_FALL_LO: n_fall[7:0] = d;
                `GPIO_FALL_HI: n_fall[15:8] = d;
                default: ;
            endcase
        end
        if (t_write && t[2:0] == `TIMER_RELOAD_LO) n_reload[7:0] = d;
        if (t_write && t[2:0] == `TIMER_RELOAD_HI) n_reload[15:8] = d;
        n_gint = ((m_sync2 & ~m_prev & m_rise) != 16'h0000)
            || ((~m_sync2 & m_prev & m_fall) != 16'h0000);
        ctrl_write = t_write && (t[2:0] == `TIMER_CTRL);
        match = m_running && (m_count == m_reload);
        n_running = m_running;
        n_count = m_count;
        n_tint = 1'b0;
        if (ctrl_write) begin
            n_ctrl = d;
            n_running = d[0];
            if (d[0]) n_count = 16'h0000;
        end else if (match) begin
            n_count = 16'h0000;
            n_tint = m_ctrl[2];
            if (m_ctrl[1]) n_running = 1'b0;
        end else if (m_running) begin
            n_count = m_count + 16'd1;
        end
        @(posedge clk);
        m_prev = m_sync2;
        m_sync2 = m_sync1;
        m_sync1 = pins_now;
        m_out = n_out;
        m_rise = n_rise;
        m_fall = n_fall;
        m_reload = n_reload;
        m_ctrl = n_ctrl;
        m_count = n_count;
        m_running = n_running;
        m_gint = n_gint;
        m_tint = n_tint;
        cycle_no++;
        #1;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic timer_write(logic [2:0] offset, bus_data_t d);
        bus_cycle(1'b1, 1'b1, `TIMER_BASE + {13'd0, offset}, d);
    endtask

    task automatic count_reads(int cycles);
        for (int i = 0; i < cycles; i++) begin
            bus_cycle(1'b1, 1'b0, `TIMER_BASE + (i[0] ? 16'd4 : 16'd3), 8'h00);
        end
    endtask

    // takes the count from the bus, low byte first.
    task automatic read_count(output logic [15:0] value);
        bus_cycle(1'b1, 1'b0, `TIMER_BASE + {13'd0, `TIMER_COUNT_LO}, 8'h00);
        value[7:0] = last_read;
        bus_cycle(1'b1, 1'b0, `TIMER_BASE + {13'd0, `TIMER_COUNT_HI}, 8'h00);
        value[15:8] = last_read;
    endtask

    task automatic program_reload(logic [15:0] value);
        timer_write(`TIMER_CTRL, 8'h00);
        timer_write(`TIMER_RELOAD_LO, value[7:0]);
        timer_write(`TIMER_RELOAD_HI, value[15:8]);
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] rl;
        logic [15:0] held;
        logic [15:0] later;
        int period;
        int frozen;
        clk = 1'b0;
        reset = 1'b0;
        enable = 1'b0;
        write_en = 1'b0;
        addr = 16'h0000;
        data_in = 8'h00;
        gpi = 16'h0000;
        pins_now = 16'h0000;
        last_read = 8'h00;
        {m_out, m_rise, m_fall, m_sync1, m_sync2, m_prev} = '0;
        {m_reload, m_count, m_ctrl, m_running, m_gint, m_tint} = '0;
        rng_state = 32'd46805;
        errors = 0;
        tests_failed = 0;
        cycle_no = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;

        begin_test("reset_state");
        for (int i = 0; i < 8; i++) begin
            bus_cycle(1'b1, 1'b0, `GPIO_BASE + 16'(i), 8'h00);
            bus_cycle(1'b1, 1'b0, `TIMER_BASE + 16'(i), 8'h00);
        end
        end_test();

        begin_test("register_access");
        repeat (access_cycles) begin
            r = next_random();
            case (r[2:0])
                3'd0, 3'd1, 3'd2: bus_cycle(1'b1, 1'b1, `GPIO_BASE + 16'(r[5:3]), r[15:8]);
                3'd3: bus_cycle(1'b1, 1'b1, `TIMER_BASE + 16'(r[4:3]), r[15:8]);
                3'd4, 3'd5: bus_cycle(1'b1, 1'b0, 16'hFF00 + 16'(r[9:5]), 8'h00);
                3'd6: bus_cycle(1'b1, 1'b0, r[31:16], 8'h00);
                default: bus_cycle(1'b0, 1'b1, `GPIO_BASE + 16'(r[5:3]), r[15:8]);
            endcase
        end
        end_test();

        begin_test("input_readback");
        repeat (input_cycles) begin
            r = next_random();
            pins_now = r[15:0];
            bus_cycle(1'b1, 1'b0, `GPIO_BASE + (r[16] ? 16'd3 : 16'd2), 8'h00);
        end
        end_test();

        begin_test("edge_interrupts");
        for (int i = 4; i < 8; i++) begin
            r = next_random();
            bus_cycle(1'b1, 1'b1, `GPIO_BASE + 16'(i), r[7:0]);
        end
        repeat (edge_cycles) begin
            r = next_random();
            // toggle a sparse set of pins so that some cycles carry no edge.
            pins_now = pins_now ^ (r[15:0] & r[31:16]);
            bus_cycle(r[20], 1'b0, `GPIO_BASE + 16'(r[23:21]), 8'h00);
        end
        end_test();

        begin_test("periodic_timer");
        r = next_random();
        rl = 16'(r[2:0]) + 16'd2;
        period = int'(rl) + 1;
        program_reload(rl);
        pulse_log.delete();
        timer_write(`TIMER_CTRL, 8'h05);
        count_reads(period * 6);
        if (pulse_log.size() < 2) begin
            errors++;
            $display("periodic timer produced %0d pulses, expected several", pulse_log.size());
        end
        for (int i = 1; i < pulse_log.size(); i++) begin
            if (pulse_log[i] - pulse_log[i - 1] != period) begin
                errors++;
                $display("timer pulses %0d cycles apart, expected %0d",
                         pulse_log[i] - pulse_log[i - 1], period);
            end
        end
        end_test();

        begin_test("oneshot_and_stop");
        r = next_random();
        rl = 16'(r[2:0]) + 16'd2;
        period = int'(rl) + 1;
        program_reload(rl);
        pulse_log.delete();
        timer_write(`TIMER_CTRL, 8'h07);
        count_reads(period * 4);
        if (pulse_log.size() != 1) begin
            errors++;
            $display("one-shot timer produced %0d pulses instead of one", pulse_log.size());
        end
        // a stopped one-shot timer keeps its count for a whole period.
        read_count(held);
        count_reads(period);
        read_count(later);
        if (later !== held) report_mismatch("count", held, later);
        pulse_log.delete();
        timer_write(`TIMER_CTRL, 8'h01);
        count_reads(period * 3 + 1);
        timer_write(`TIMER_CTRL, 8'h00);
        frozen = int'(m_count);
        count_reads(12);
        read_count(later);
        if (later !== 16'(frozen)) report_mismatch("count", 16'(frozen), later);
        if (pulse_log.size() != 0) begin
            errors++;
            $display("timer pulsed %0d times with its interrupt disabled", pulse_log.size());
        end
        end_test();

        $display("tests failed %0d of 6, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* bench/periph_assertions.sv */
`timescale 1ns/1ps

module periph_assertions (
    input logic clk,
    input logic reset,
    input logic enable,
    input periph_pkg::bus_data_t data_out,
    input periph_pkg::pin_word_t gpo,
    input logic gpio_interrupt,
    input logic timer_interrupt,
    input periph_pkg::pin_word_t gpi_level,
    input logic [15:0] reload
);

    import periph_pkg::*;

    read_idle: assert property (@(posedge clk) disable iff (!reset)
        !enable |-> data_out == 8'h00)
        else $error("data_out is not zero while enable is low");

    // without a change of the synchronized level there is no edge to report.
    gpio_pulse: assert property (@(posedge clk) disable iff (!reset)
        gpio_interrupt && $stable(gpi_level) |=> !gpio_interrupt)
        else $error("gpio_interrupt stayed high without a new edge");

    // the count restarts from zero at a match, so only a zero reload matches twice in a row.
    timer_pulse: assert property (@(posedge clk) disable iff (!reset)
        timer_interrupt && reload != 16'h0000 |=> !timer_interrupt)
        else $error("timer_interrupt stayed high without a new match");

    // first sampled edge after reset release still shows the reset values.
    reset_state: assert property (@(posedge clk)
        $rose(reset) |-> gpo == 16'h0000 && !gpio_interrupt && !timer_interrupt)
        else $error("outputs not cleared by reset");

endmodule

/* verilog/periph_bus.sv */
`timescale 1ns/1ps

module periph_bus (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic write_en,
    input periph_pkg::bus_addr_t addr,
    input periph_pkg::bus_data_t data_in,
    output periph_pkg::bus_data_t data_out,
    input periph_pkg::pin_word_t gpi,
    output periph_pkg::pin_word_t gpo,
    output logic gpio_interrupt,
    output logic timer_interrupt
);

    import periph_pkg::*;

    bus_data_t gpio_data;
    bus_data_t timer_data;

    // both peripherals see the raw bus and decode their own windows.
    gpio gpio_unit (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .write_en(write_en),
        .addr(addr),
        .data_in(data_in),
        .data_out(gpio_data),
        .gpi(gpi),
        .gpo(gpo),
        .interrupt(gpio_interrupt)
    );

    timer timer_unit (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .write_en(write_en),
        .addr(addr),
        .data_in(data_in),
        .data_out(timer_data),
        .interrupt(timer_interrupt)
    );

    // the windows do not overlap, and an unselected peripheral drives zero.
    assign data_out = gpio_data | timer_data;

endmodule

/* verilog/timer.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module timer (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic write_en,
    input periph_pkg::bus_addr_t addr,
    input periph_pkg::bus_data_t data_in,
    output periph_pkg::bus_data_t data_out,
    output logic interrupt
);

    import periph_pkg::*;

    bus_addr_t relative;
    reg_access_t access;

    bus_data_t reload_lo_rd;
    bus_data_t reload_hi_rd;
    bus_data_t ctrl_rd;
    bus_data_t ctrl_value;
    bus_data_t count_lo_rd;
    bus_data_t count_hi_rd;

    logic [15:0] reload;
    logic [15:0] count;
    timer_state_t state;
    timer_state_t next_state;

    logic ctrl_write;
    logic start_write;
    logic match;

    assign relative = addr - `TIMER_BASE;

    assign access = '{
        select: enable && (relative < `WINDOW_SIZE),
        offset: relative[2:0],
        write_en: write_en,
        data: data_in
    };

    bus_register #(.reg_offset(`TIMER_RELOAD_LO), .reset_value(8'h00)) reload_lo_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(reload[7:0]), .read_data(reload_lo_rd)
    );

    bus_register #(.reg_offset(`TIMER_RELOAD_HI), .reset_value(8'h00)) reload_hi_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(reload[15:8]), .read_data(reload_hi_rd)
    );

    bus_register #(.reg_offset(`TIMER_CTRL), .reset_value(8'h00)) ctrl_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(ctrl_value), .read_data(ctrl_rd)
    );

    assign ctrl_write = access.select && access.write_en && (access.offset == `TIMER_CTRL);
    assign start_write = ctrl_write && access.data[0];
    assign match = (state == timer_running) && (count == reload);

    // a control write always wins over the match in the same cycle.
    always_comb begin
        next_state = state;
        case (state)
            timer_stopped: if (start_write) next_state = timer_running;
            timer_running: begin
                if (ctrl_write && !access.data[0]) begin
                    next_state = timer_stopped;
                end else if (!ctrl_write && match && ctrl_value[1]) begin
                    next_state = timer_stopped;
                end
            end
            default: next_state = timer_stopped;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= timer_stopped;
            count <= '0;
            interrupt <= 1'b0;
        end else begin
            state <= next_state;
            interrupt <= match && !ctrl_write && ctrl_value[2];
            if (start_write || (match && !ctrl_write)) begin
                count <= '0;
            end else if (state == timer_running && !ctrl_write) begin
                count <= count + 16'd1;
            end
        end
    end

    assign count_lo_rd = (access.select && access.offset == `TIMER_COUNT_LO) ? count[7:0] : '0;
    assign count_hi_rd = (access.select && access.offset == `TIMER_COUNT_HI) ? count[15:8] : '0;

    assign data_out = reload_lo_rd | reload_hi_rd | ctrl_rd | count_lo_rd | count_hi_rd;

endmodule

/* verilog/gpio.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module gpio (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic write_en,
    input periph_pkg::bus_addr_t addr,
    input periph_pkg::bus_data_t data_in,
    output periph_pkg::bus_data_t data_out,
    input periph_pkg::pin_word_t gpi,
    output periph_pkg::pin_word_t gpo,
    output logic interrupt
);

    import periph_pkg::*;

    bus_addr_t relative;
    reg_access_t access;

    bus_data_t out_lo_rd;
    bus_data_t out_hi_rd;
    bus_data_t rise_lo_rd;
    bus_data_t rise_hi_rd;
    bus_data_t fall_lo_rd;
    bus_data_t fall_hi_rd;
    bus_data_t in_lo_rd;
    bus_data_t in_hi_rd;

    pin_word_t rise_mask;
    pin_word_t fall_mask;
    pin_word_t in_level;
    pin_word_t in_rising;
    pin_word_t in_falling;

    // the subtraction wraps below the base, so one compare bounds the window.
    assign relative = addr - `GPIO_BASE;

    assign access = '{
        select: enable && (relative < `WINDOW_SIZE),
        offset: relative[2:0],
        write_en: write_en,
        data: data_in
    };

    bus_register #(.reg_offset(`GPIO_OUT_LO), .reset_value(8'h00)) out_lo_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(gpo[7:0]), .read_data(out_lo_rd)
    );

    bus_register #(.reg_offset(`GPIO_OUT_HI), .reset_value(8'h00)) out_hi_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(gpo[15:8]), .read_data(out_hi_rd)
    );

    bus_register #(.reg_offset(`GPIO_RISE_LO), .reset_value(8'h00)) rise_lo_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(rise_mask[7:0]), .read_data(rise_lo_rd)
    );

    bus_register #(.reg_offset(`GPIO_RISE_HI), .reset_value(8'h00)) rise_hi_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(rise_mask[15:8]), .read_data(rise_hi_rd)
    );

    bus_register #(.reg_offset(`GPIO_FALL_LO), .reset_value(8'h00)) fall_lo_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(fall_mask[7:0]), .read_data(fall_lo_rd)
    );

    bus_register #(.reg_offset(`GPIO_FALL_HI), .reset_value(8'h00)) fall_hi_reg (
        .clk(clk), .reset(reset), .access(access),
        .value(fall_mask[15:8]), .read_data(fall_hi_rd)
    );

    gpio_sync input_sync (
        .clk(clk),
        .reset(reset),
        .pins(gpi),
        .level(in_level),
        .rising(in_rising),
        .falling(in_falling)
    );

    // the inputs are read only, so they are muxed here rather than stored in a cell.
    assign in_lo_rd = (access.select && access.offset == `GPIO_IN_LO) ? in_level[7:0] : '0;
    assign in_hi_rd = (access.select && access.offset == `GPIO_IN_HI) ? in_level[15:8] : '0;

    always_ff @(posedge clk) begin
        if (!reset) begin
            interrupt <= 1'b0;
        end else begin
            interrupt <= |(in_rising & rise_mask) | |(in_falling & fall_mask);
        end
    end

    assign data_out = out_lo_rd | out_hi_rd | in_lo_rd | in_hi_rd
                    | rise_lo_rd | rise_hi_rd | fall_lo_rd | fall_hi_rd;

endmodule

/* verilog/gpio_sync.sv */
`timescale 1ns/1ps

module gpio_sync (
    input logic clk,
    input logic reset,
    input periph_pkg::pin_word_t pins,
    output periph_pkg::pin_word_t level,
    output periph_pkg::pin_word_t rising,
    output periph_pkg::pin_word_t falling
);

    import periph_pkg::*;

    pin_word_t stage1;
    pin_word_t stage2;
    pin_word_t previous;

    // two flops take the asynchronous pins into the clock domain.
    always_ff @(posedge clk) begin
        if (!reset) begin
            stage1 <= '0;
            stage2 <= '0;
        end else begin
            stage1 <= pins;
            stage2 <= stage1;
        end
    end

    // previous copy of the synchronized level for edge detection.
    always_ff @(posedge clk) begin
        if (!reset) begin
            previous <= '0;
        end else begin
            previous <= stage2;
        end
    end

    assign level = stage2;

    // per-bit edges, so every pin is judged on its own.
    assign rising = stage2 & ~previous;
    assign falling = ~stage2 & previous;

endmodule

/* verilog/bus_register.sv */
`timescale 1ns/1ps

module bus_register #(
    parameter periph_pkg::reg_offset_t reg_offset = '0,
    parameter periph_pkg::bus_data_t reset_value = '0
) (
    input logic clk,
    input logic reset,
    input periph_pkg::reg_access_t access,
    output periph_pkg::bus_data_t value,
    output periph_pkg::bus_data_t read_data
);

    import periph_pkg::*;

    bus_data_t stored;
    logic hit;

    // the cell answers only when its window is selected at its own offset.
    assign hit = access.select && (access.offset == reg_offset);

    always_ff @(posedge clk) begin
        if (!reset) begin
            stored <= reset_value;
        end else if (hit && access.write_en) begin
            stored <= access.data;
        end
    end

    assign value = stored;

    // zero when not addressed, so the peripheral can OR all cells together.
    assign read_data = hit ? stored : '0;

endmodule

/* verilog/periph_pkg.sv */
package periph_pkg;

    // system bus address and data widths.
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // offset of a register inside an eight-byte window.
    typedef logic [2:0] reg_offset_t;

    // one bit per GPIO pin.
    typedef logic [15:0] pin_word_t;

    // a decoded bus access as seen by the register cells of one peripheral.
    typedef struct packed {
        logic select;
        reg_offset_t offset;
        logic write_en;
        bus_data_t data;
    } reg_access_t;

    typedef enum logic {
        timer_stopped,
        timer_running
    } timer_state_t;

endpackage

/* verilog/periph_macros.svh */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// window bases on the system bus.
`define GPIO_BASE 16'hFF07
`define TIMER_BASE 16'hFF10

// each peripheral decodes eight consecutive byte addresses.
`define WINDOW_SIZE 16'd8

`define GPIO_OUT_LO 3'd0
`define GPIO_OUT_HI 3'd1
`define GPIO_IN_LO 3'd2
`define GPIO_IN_HI 3'd3
`define GPIO_RISE_LO 3'd4
`define GPIO_RISE_HI 3'd5
`define GPIO_FALL_LO 3'd6
`define GPIO_FALL_HI 3'd7

// control byte: bit 0 start, bit 1 one-shot, bit 2 interrupt enable.
`define TIMER_RELOAD_LO 3'd0
`define TIMER_RELOAD_HI 3'd1
`define TIMER_CTRL 3'd2
`define TIMER_COUNT_LO 3'd3
`define TIMER_COUNT_HI 3'd4

`endif
